// ==== axis_stream_top.f ====
+incdir+include
source/axis_pkg.sv
source/axis_if.sv
source/axis_fifo.sv
source/axis_accumulator.sv
source/axis_stream_top.sv
test/axis_stream_sva.sv
test/axis_stream_tb.sv

// ==== include/axis_params.svh ====
`ifndef AXIS_PARAMS_SVH
`define AXIS_PARAMS_SVH

// width of one unsigned input sample
`define AXIS_SAMPLE_W 16

// running sum width, saturates at all ones
`define AXIS_SUM_W 20

// beat index width, index wraps modulo 2**AXIS_CNT_W
`define AXIS_CNT_W 8

// input fifo depth in beats
`define AXIS_IN_DEPTH 16

// output fifo depth in beats
// smaller than the input side, the accumulator slot adds one more
`define AXIS_OUT_DEPTH 8

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run with verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module axis_stream_tb \
    -f axis_stream_top.f -o axis_stream_sim > build.log 2>&1 \
    && ./obj_dir/axis_stream_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

// ==== source/axis_accumulator.sv ====
`timescale 1ns/1ps

`include "axis_params.svh"

// per packet running sum and beat index
// each accepted sample yields one result beat in a registered slot
module axis_accumulator (
    input logic    clk_i,
    input logic    arstn_i,

    // carries axis_pkg::sample_beat_t
    axis_if.slave  s_axis,
    // carries axis_pkg::result_beat_t
    axis_if.master m_axis
);

    localparam int SAMPLE_W = `AXIS_SAMPLE_W;
    localparam int SUM_W    = `AXIS_SUM_W;
    localparam int CNT_W    = `AXIS_CNT_W;

    // packet state, describes the beat that comes next
    logic [SUM_W-1:0] sum_q;
    logic [CNT_W-1:0] idx_q;

    // output slot
    logic                   slot_valid_q;
    axis_pkg::result_beat_t slot_q;

    // input beat and handshakes
    axis_pkg::sample_beat_t in_beat;
    logic                   take_in;
    logic                   take_out;

    // saturating add, one extra bit catches the carry
    logic [SUM_W:0]   sum_wide;
    logic [SUM_W-1:0] sum_new;

    assign in_beat  = s_axis.tdata;
    assign take_in  = s_axis.tvalid & s_axis.tready;
    assign take_out = m_axis.tvalid & m_axis.tready;

    // sample zero extended to the sum width plus carry
    assign sum_wide = {1'b0, sum_q} + {{(SUM_W + 1 - SAMPLE_W){1'b0}}, in_beat.sample};
    // clamp on carry out
    assign sum_new  = sum_wide[SUM_W] ? axis_pkg::SUM_MAX : sum_wide[SUM_W-1:0];

    // accept while the slot is free or drains in this cycle
    // this keeps one beat per cycle possible
    assign s_axis.tready = ~slot_valid_q | take_out;

    // packet state, back to zero after a last beat
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            sum_q <= '0;
            idx_q <= '0;
        end else if (take_in) begin
            if (in_beat.last) begin
                sum_q <= '0;
                idx_q <= '0;
            end else begin
                sum_q <= sum_new;
                // index simply wraps at the counter width
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // slot valid flag
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            slot_valid_q <= 1'b0;
        end else if (take_in) begin
            slot_valid_q <= 1'b1;
        end else if (take_out) begin
            slot_valid_q <= 1'b0;
        end
    end

    // slot payload, loaded with each accepted beat
    // holds while the downstream stalls since take_in is low then
    always_ff @(posedge clk_i) begin
        if (take_in) begin
            slot_q.sum   <= sum_new;
            slot_q.index <= idx_q;
            slot_q.last  <= in_beat.last;
        end
    end

    assign m_axis.tvalid = slot_valid_q;
    assign m_axis.tdata  = slot_q;

endmodule

// ==== source/axis_fifo.sv ====
`timescale 1ns/1ps

// stream fifo on a circular buffer
// full and empty come from the pointers plus one lap flag per pointer
// depth does not have to be a power of two
module axis_fifo #(
    parameter int  FIFO_DEPTH = 16,
    parameter type payload_t  = logic [7:0]
) (
    input logic    clk_i,
    input logic    arstn_i,

    axis_if.slave  s_axis,
    axis_if.master m_axis
);

    // a depth of one still needs a one bit pointer
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] MAX_PTR = PTR_W'(FIFO_DEPTH - 1);

    // storage
    payload_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    // lap flags, toggled each time the pointer wraps
    logic             rd_lap;
    logic             wr_lap;

    logic push;
    logic pop;
    logic full;
    logic empty;

    // handshakes on both sides
    assign push = s_axis.tvalid & s_axis.tready;
    assign pop  = m_axis.tvalid & m_axis.tready;

    // same slot, different lap means the writer is a lap ahead
    assign full  = (wr_ptr == rd_ptr) && (wr_lap != rd_lap);
    // same slot, same lap means nothing stored
    assign empty = (wr_ptr == rd_ptr) && (wr_lap == rd_lap);

    // write pointer
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
            wr_lap <= 1'b0;
        end else if (push) begin
            if (wr_ptr == MAX_PTR) begin
                // wrap to slot 0 and start a new lap
                wr_ptr <= '0;
                wr_lap <= ~wr_lap;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // read pointer
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rd_ptr <= '0;
            rd_lap <= 1'b0;
        end else if (pop) begin
            if (rd_ptr == MAX_PTR) begin
                rd_ptr <= '0;
                rd_lap <= ~rd_lap;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage write, payload only
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= s_axis.tdata;
        end
    end

    // head of the queue goes out without a register stage
    // a beat written on one edge is visible from that edge on
    assign m_axis.tdata  = mem[rd_ptr];
    assign m_axis.tvalid = ~empty;

    // refuse input only when all FIFO_DEPTH slots are taken
    // a pop in the same cycle does not open a slot early
    assign s_axis.tready = ~full;

endmodule

// ==== source/axis_if.sv ====
`timescale 1ns/1ps

// axi-stream link with a typed payload
// a beat moves on a rising edge with tvalid and tready both high
// the master keeps tvalid and tdata steady until that edge
interface axis_if #(
    parameter type payload_t = logic [7:0]
) ();

    logic     tvalid;
    logic     tready;
    payload_t tdata;

    // producer side
    modport master (
        output tvalid,
        output tdata,
        input  tready
    );

    // consumer side
    modport slave (
        input  tvalid,
        input  tdata,
        output tready
    );

endinterface

// ==== source/axis_pkg.sv ====
`include "axis_params.svh"

package axis_pkg;

    // one incoming sample beat
    // last marks the final beat of a packet
    typedef struct packed {
        logic [`AXIS_SAMPLE_W-1:0] sample;
        logic                      last;
    } sample_beat_t;

    // one result beat produced by the accumulator
    // sum is the saturated running sum of the packet up to and
    // including this beat
    // index counts beats within the packet, first beat is 0
    // last is copied from the matching input beat
    typedef struct packed {
        logic [`AXIS_SUM_W-1:0] sum;
        logic [`AXIS_CNT_W-1:0] index;
        logic                   last;
    } result_beat_t;

    // ceiling value of the running sum
    localparam logic [`AXIS_SUM_W-1:0] SUM_MAX = '1;

endpackage

// ==== source/axis_stream_top.sv ====
`timescale 1ns/1ps

`include "axis_params.svh"

// input fifo, then accumulator, then output fifo
module axis_stream_top (
    input  logic                   clk_i,
    input  logic                   arstn_i,

    // upstream samples
    input  axis_pkg::sample_beat_t s_tdata_i,
    input  logic                   s_tvalid_i,
    output logic                   s_tready_o,

    // downstream results
    output axis_pkg::result_beat_t m_tdata_o,
    output logic                   m_tvalid_o,
    input  logic                   m_tready_i
);

    // boundary links and the two internal links
    axis_if #(.payload_t(axis_pkg::sample_beat_t)) s_if   ();
    axis_if #(.payload_t(axis_pkg::sample_beat_t)) in_if  ();
    axis_if #(.payload_t(axis_pkg::result_beat_t)) out_if ();
    axis_if #(.payload_t(axis_pkg::result_beat_t)) m_if   ();

    // plain upstream ports onto the input link
    assign s_if.tdata  = s_tdata_i;
    assign s_if.tvalid = s_tvalid_i;
    assign s_tready_o  = s_if.tready;

    // output link onto plain downstream ports
    assign m_tdata_o   = m_if.tdata;
    assign m_tvalid_o  = m_if.tvalid;
    assign m_if.tready = m_tready_i;

    // buffers bursts from upstream
    axis_fifo #(
        .FIFO_DEPTH (`AXIS_IN_DEPTH),
        .payload_t  (axis_pkg::sample_beat_t)
    ) u_in_fifo (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .s_axis  (s_if),
        .m_axis  (in_if)
    );

    axis_accumulator u_accum (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .s_axis  (in_if),
        .m_axis  (out_if)
    );

    // absorbs downstream stalls first
    axis_fifo #(
        .FIFO_DEPTH (`AXIS_OUT_DEPTH),
        .payload_t  (axis_pkg::result_beat_t)
    ) u_out_fifo (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .s_axis  (out_if),
        .m_axis  (m_if)
    );

endmodule

// ==== test/axis_stream_sva.sv ====
`timescale 1ns/1ps

// stream protocol checks on the top level
module axis_stream_sva (
    input logic                   clk_i,
    input logic                   arstn_i,
    input logic                   m_tvalid_i,
    input logic                   m_tready_i,
    input axis_pkg::result_beat_t m_tdata_i,
    input logic                   out_tvalid_i,
    input logic                   out_tready_i,
    input axis_pkg::result_beat_t out_tdata_i
);

    // a stalled output beat stays offered and unchanged
    a_out_hold: assert property (@(posedge clk_i) disable iff (!arstn_i)
        m_tvalid_i && !m_tready_i |=> m_tvalid_i && $stable(m_tdata_i))
        else $error("output beat changed or dropped while stalled");

    // accumulator slot holds while refused
    // a full output fifo is the usual cause
    a_slot_hold: assert property (@(posedge clk_i) disable iff (!arstn_i)
        out_tvalid_i && !out_tready_i |=> out_tvalid_i && $stable(out_tdata_i))
        else $error("accumulator slot changed while stalled");

    // nothing offered downstream during reset
    a_reset_idle: assert property (@(posedge clk_i) !arstn_i |-> !m_tvalid_i)
        else $error("output valid high during reset");

endmodule

bind axis_stream_top axis_stream_sva u_sva (
    .clk_i        (clk_i),
    .arstn_i      (arstn_i),
    .m_tvalid_i   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tdata_i    (m_tdata_o),
    .out_tvalid_i (out_if.tvalid),
    .out_tready_i (out_if.tready),
    .out_tdata_i  (out_if.tdata)
);

// ==== test/axis_stream_tb.sv ====
`timescale 1ns/1ps

`include "axis_params.svh"

module axis_stream_tb;

    localparam int SAMPLE_W  = `AXIS_SAMPLE_W;
    localparam int SUM_W     = `AXIS_SUM_W;
    localparam int CNT_W     = `AXIS_CNT_W;
    // ceiling of the running sum and modulus of the index
    localparam int SUM_LIMIT = (1 << `AXIS_SUM_W) - 1;
    localparam int CNT_MOD   = 1 << `AXIS_CNT_W;
    localparam int MAX_WAIT  = 2000;

    logic                   clk_i;
    logic                   arstn_i;
    axis_pkg::sample_beat_t s_tdata_i;
    logic                   s_tvalid_i;
    logic                   s_tready_o;
    axis_pkg::result_beat_t m_tdata_o;
    logic                   m_tvalid_o;
    logic                   m_tready_i;

    // stimulus and ready pattern step separate xorshift states
    logic [31:0] stim_rng;
    logic [31:0] ready_rng;
    logic        ready_random;

    // reference model, state of the next beat plus scoreboard
    int unsigned            model_sum;
    int unsigned            model_idx;
    axis_pkg::result_beat_t expected_q[$];

    string test_name;
    int    value_errors;
    int    timeout_errors;
    int    stray_errors;

    axis_stream_top DUT (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .s_tdata_i  (s_tdata_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tready_o (s_tready_o),
        .m_tdata_o  (m_tdata_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tready_i (m_tready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned draw(input int unsigned range);
        stim_rng = xorshift32(stim_rng);
        return stim_rng % range;
    endfunction

    task automatic check_result(input string name, input axis_pkg::result_beat_t exp,
                                input axis_pkg::result_beat_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: exp sum=%0d idx=%0d last=%0b, act sum=%0d idx=%0d last=%0b",
                     name, exp.sum, exp.index, exp.last, act.sum, act.index, act.last);
        end
    endtask

    task automatic check_idle(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // saturating sum, index from 0, both restart after a last beat
    task automatic model_accept(input axis_pkg::sample_beat_t beat);
        axis_pkg::result_beat_t res;
        int unsigned            total;
        total = model_sum + beat.sample;
        if (total > SUM_LIMIT) begin
            total = SUM_LIMIT;
        end
        res.sum   = SUM_W'(total);
        res.index = CNT_W'(model_idx);
        res.last  = beat.last;
        expected_q.push_back(res);
        if (beat.last) begin
            model_sum = 0;
            model_idx = 0;
        end else begin
            model_sum = total;
            model_idx = (model_idx + 1) % CNT_MOD;
        end
    endtask

    // handshake values are settled half a cycle before the edge that takes them
    always @(negedge clk_i) begin
        if (arstn_i) begin
            if (s_tvalid_i && s_tready_o) begin
                model_accept(s_tdata_i);
            end
            if (m_tvalid_o && m_tready_i) begin
                if (expected_q.size() == 0) begin
                    stray_errors++;
                    $display("%s: result beat arrived while none was expected", test_name);
                end else begin
                    check_result(test_name, expected_q.pop_front(), m_tdata_o);
                end
            end
        end
    end

    // downstream ready, low on about 40% of cycles when random
    always @(posedge clk_i) begin
        #2;
        if (ready_random) begin
            ready_rng  = xorshift32(ready_rng);
            m_tready_i = (ready_rng % 100) >= 40;
        end
    end

    task automatic send_beat(input logic [SAMPLE_W-1:0] sample, input logic last,
                             input bit gaps);
        int   waited;
        logic taken;
        if (gaps) begin
            repeat (draw(3)) begin
                s_tvalid_i = 1'b0;
                @(posedge clk_i);
                #2;
            end
        end
        s_tdata_i.sample = sample;
        s_tdata_i.last   = last;
        s_tvalid_i       = 1'b1;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < MAX_WAIT) begin
            @(negedge clk_i);
            taken = s_tready_o;
            @(posedge clk_i);
            #2;
            waited++;
        end
        if (!taken) begin
            timeout_errors++;
            $display("%s: input beat not accepted within %0d cycles", test_name, MAX_WAIT);
        end
    endtask

    // kind 1 is all ones, kind 2 small values, otherwise full range
    task automatic send_packet(input int len, input int kind, input bit gaps);
        logic [SAMPLE_W-1:0] sample;
        for (int i = 0; i < len; i++) begin
            case (kind)
                1:       sample = '1;
                2:       sample = SAMPLE_W'(draw(16));
                default: sample = SAMPLE_W'(draw(1 << SAMPLE_W));
            endcase
            send_beat(sample, i == len - 1, gaps);
        end
        s_tvalid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < MAX_WAIT) begin
            @(posedge clk_i);
            #2;
            waited++;
        end
        if (expected_q.size() != 0) begin
            timeout_errors++;
            $display("%s: %0d results still missing after %0d cycles",
                     test_name, expected_q.size(), MAX_WAIT);
        end
    endtask

    // model is emptied together with the DUT
    task automatic apply_reset(input int cycles);
        arstn_i    = 1'b0;
        s_tvalid_i = 1'b0;
        expected_q.delete();
        model_sum = 0;
        model_idx = 0;
        repeat (cycles) @(posedge clk_i);
        check_idle({test_name, " m_tvalid in reset"}, 1'b0, m_tvalid_o);
        check_idle({test_name, " s_tready in reset"}, 1'b1, s_tready_o);
        #2;
        arstn_i = 1'b1;
    endtask

    initial begin
        stim_rng       = 32'd35;
        ready_rng      = ~32'd35;
        ready_random   = 1'b0;
        m_tready_i     = 1'b1;
        s_tvalid_i     = 1'b0;
        s_tdata_i      = '0;
        arstn_i        = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        stray_errors   = 0;
        test_name      = "reset";
        apply_reset(8);

        test_name = "stream";
        repeat (20) send_packet(1 + draw(6), 0, 1'b0);
        wait_drain();

        test_name    = "backpressure";
        ready_random = 1'b1;
        repeat (30) send_packet(1 + draw(6), 0, 1'b1);
        ready_random = 1'b0;
        m_tready_i   = 1'b1;
        wait_drain();

        test_name = "saturation";
        send_packet(20, 1, 1'b0);
        wait_drain();

        // 300 beats wrap the index, the following packet starts over
        test_name = "index_wrap";
        send_packet(300, 2, 1'b0);
        send_packet(3, 2, 1'b0);
        wait_drain();

        // stall the output so both fifos hold beats, then reset
        test_name  = "reset_mid";
        m_tready_i = 1'b0;
        send_packet(12, 0, 1'b0);
        repeat (4) begin
            @(posedge clk_i);
            #2;
        end
        apply_reset(3);
        @(negedge clk_i);
        check_idle("reset_mid m_tvalid after reset", 1'b0, m_tvalid_o);
        check_idle("reset_mid s_tready after reset", 1'b1, s_tready_o);
        @(posedge clk_i);
        #2;
        m_tready_i = 1'b1;
        send_packet(4, 0, 1'b0);
        wait_drain();

        $display("errors: value %0d, timeout %0d, unexpected output %0d",
                 value_errors, timeout_errors, stray_errors);
        if (value_errors + timeout_errors + stray_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
